// File: src/isaPkg.sv
`default_nettype none

package isaPkg;

	// Field layout of a 16-bit instruction word
	localparam int OpcodeMsb = 15;
	localparam int DstMsb = 11;
	localparam int SrcMsb = 7;
	localparam int FieldWidth = 4;

	// Immediate sits in the low byte over the source field
	localparam int ImmWidth = 8;

	typedef enum logic [FieldWidth-1:0] {
		NOP  = 4'h0,
		ADD  = 4'h1,
		SUB  = 4'h2,
		AND  = 4'h3,
		OR   = 4'h4,
		XOR  = 4'h5,
		SHR  = 4'h6,
		MOV  = 4'h7,
		LDI  = 4'h8,
		LD   = 4'h9,
		ST   = 4'hA,
		JMP  = 4'hB,
		JR   = 4'hC,
		BZ   = 4'hD,
		BC   = 4'hE,
		HALT = 4'hF
	} opcodeT;

endpackage

`default_nettype wire

// File: src/corePkg.sv
`default_nettype none

package corePkg;

	localparam int DataWidth = 16;
	localparam int AddrWidth = 16;
	localparam int RegCount = 16;
	localparam int RegIdxWidth = $clog2(RegCount);

	typedef enum logic [1:0] {
		FETCH,
		EXEC,
		MEMACC,
		HALTED
	} stateT;

	// Next PC source
	typedef enum logic [1:0] {PC_INCR, PC_IMM, PC_REG} pcSelT;

	// Register write-back source
	typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_SRC, WB_MEM} wbSelT;

endpackage

`default_nettype wire

// File: src/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input wire logic clk,
	input wire logic rst,
	input wire logic we,
	input wire logic [corePkg::RegIdxWidth-1:0] dstIdx,
	input wire logic [corePkg::RegIdxWidth-1:0] srcIdx,
	input wire logic [corePkg::DataWidth-1:0] writeData,
	output logic [corePkg::DataWidth-1:0] dstData,
	output logic [corePkg::DataWidth-1:0] srcData
);

	logic [corePkg::DataWidth-1:0] regs [corePkg::RegCount];

	// Single write port addressed by the destination index
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < corePkg::RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[dstIdx] <= writeData;
		end
	end

	// Both reads are asynchronous
	always_comb begin
		dstData = regs[dstIdx];
		srcData = regs[srcIdx];
	end

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire logic clk,
	input wire logic rst,
	input wire isaPkg::opcodeT op,
	input wire logic flagEn,
	input wire logic [corePkg::DataWidth-1:0] a,
	input wire logic [corePkg::DataWidth-1:0] b,
	output logic [corePkg::DataWidth-1:0] result,
	output logic cFlag,
	output logic zFlag
);

	// Top bit carries the carry, borrow or shifted-out bit
	logic [corePkg::DataWidth:0] wide;
	logic carryNext;
	logic zeroNext;

	always_comb begin
		case (op)
			isaPkg::ADD: begin
				wide = {1'b0, a} + {1'b0, b};
			end
			isaPkg::SUB: begin
				wide = {1'b0, a} - {1'b0, b};
			end
			isaPkg::AND: begin
				wide = {1'b0, a & b};
			end
			isaPkg::OR: begin
				wide = {1'b0, a | b};
			end
			isaPkg::XOR: begin
				wide = {1'b0, a ^ b};
			end
			isaPkg::SHR: begin
				wide = {a[0], 1'b0, a[corePkg::DataWidth-1:1]};
			end
			default: begin
				wide = {1'b0, b};
			end
		endcase
	end

	assign result = wide[corePkg::DataWidth-1:0];
	assign carryNext = wide[corePkg::DataWidth];
	assign zeroNext = (result == '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagEn) begin
			cFlag <= carryNext;
			zFlag <= zeroNext;
		end
	end

endmodule

`default_nettype wire

// File: src/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input wire logic [corePkg::DataWidth-1:0] instruction,
	input wire logic cFlag,
	input wire logic zFlag,
	output isaPkg::opcodeT op,
	output logic [corePkg::RegIdxWidth-1:0] dstIdx,
	output logic [corePkg::RegIdxWidth-1:0] srcIdx,
	output logic [corePkg::DataWidth-1:0] imm,
	output logic regWe,
	output logic flagEn,
	output corePkg::wbSelT wbSel,
	output corePkg::pcSelT pcSel,
	output logic memRead,
	output logic memWrite,
	output logic halt
);

	assign op = isaPkg::opcodeT'(instruction[isaPkg::OpcodeMsb -: isaPkg::FieldWidth]);
	assign dstIdx = instruction[isaPkg::DstMsb -: isaPkg::FieldWidth];
	assign srcIdx = instruction[isaPkg::SrcMsb -: isaPkg::FieldWidth];
	assign imm = {{(corePkg::DataWidth - isaPkg::ImmWidth){1'b0}},
		instruction[isaPkg::ImmWidth-1:0]};

	always_comb begin
		regWe = 1'b0;
		flagEn = 1'b0;
		wbSel = corePkg::WB_ALU;
		pcSel = corePkg::PC_INCR;
		memRead = 1'b0;
		memWrite = 1'b0;
		halt = 1'b0;
		case (op)
			isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR, isaPkg::XOR, isaPkg::SHR: begin
				regWe = 1'b1;
				flagEn = 1'b1;
			end
			isaPkg::MOV: begin
				regWe = 1'b1;
				wbSel = corePkg::WB_SRC;
			end
			isaPkg::LDI: begin
				regWe = 1'b1;
				wbSel = corePkg::WB_IMM;
			end
			isaPkg::LD: begin
				regWe = 1'b1;
				wbSel = corePkg::WB_MEM;
				memRead = 1'b1;
			end
			isaPkg::ST: memWrite = 1'b1;
			isaPkg::JMP: pcSel = corePkg::PC_IMM;
			isaPkg::JR: pcSel = corePkg::PC_REG;
			// Conditional branches fall through when the flag is clear
			isaPkg::BZ: pcSel = zFlag ? corePkg::PC_IMM : corePkg::PC_INCR;
			isaPkg::BC: pcSel = cFlag ? corePkg::PC_IMM : corePkg::PC_INCR;
			isaPkg::HALT: halt = 1'b1;
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
	input wire logic clk,
	input wire logic rst,
	output logic cyc,
	output logic stb,
	output logic we,
	output logic [corePkg::AddrWidth-1:0] adr,
	output logic [corePkg::DataWidth-1:0] datOut,
	input wire logic [corePkg::DataWidth-1:0] datIn,
	input wire logic ack,
	output logic halted
);

	corePkg::stateT state;
	logic [corePkg::AddrWidth-1:0] pc;
	logic [corePkg::AddrWidth-1:0] nextPc;
	logic [corePkg::DataWidth-1:0] instr;

	isaPkg::opcodeT op;
	logic [corePkg::RegIdxWidth-1:0] dstIdx;
	logic [corePkg::RegIdxWidth-1:0] srcIdx;
	logic [corePkg::DataWidth-1:0] imm;
	logic regWe;
	logic flagEn;
	corePkg::wbSelT wbSel;
	corePkg::pcSelT pcSel;
	logic memRead;
	logic memWrite;
	logic halt;

	logic [corePkg::DataWidth-1:0] dstData;
	logic [corePkg::DataWidth-1:0] srcData;
	logic [corePkg::DataWidth-1:0] writeData;
	logic [corePkg::DataWidth-1:0] aluResult;
	logic cFlag;
	logic zFlag;
	logic regWrite;
	logic flagWrite;
	logic loadDone;

	decoder decoder_i (
		.instruction(instr),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.op(op),
		.dstIdx(dstIdx),
		.srcIdx(srcIdx),
		.imm(imm),
		.regWe(regWe),
		.flagEn(flagEn),
		.wbSel(wbSel),
		.pcSel(pcSel),
		.memRead(memRead),
		.memWrite(memWrite),
		.halt(halt)
	);

	registerFile registerFile_i (
		.clk(clk),
		.rst(rst),
		.we(regWrite),
		.dstIdx(dstIdx),
		.srcIdx(srcIdx),
		.writeData(writeData),
		.dstData(dstData),
		.srcData(srcData)
	);

	alu alu_i (
		.clk(clk),
		.rst(rst),
		.op(op),
		.flagEn(flagWrite),
		.a(dstData),
		.b(srcData),
		.result(aluResult),
		.cFlag(cFlag),
		.zFlag(zFlag)
	);

	// Loads write back only when the data transfer completes
	assign loadDone = (state == corePkg::MEMACC) && cyc && ack && memRead;
	assign regWrite = ((state == corePkg::EXEC) && regWe && !memRead) || loadDone;
	assign flagWrite = (state == corePkg::EXEC) && flagEn;
	assign stb = cyc;
	assign halted = (state == corePkg::HALTED);

	always_comb begin
		case (wbSel)
			corePkg::WB_IMM: writeData = imm;
			corePkg::WB_SRC: writeData = srcData;
			corePkg::WB_MEM: writeData = datIn;
			default: writeData = aluResult;
		endcase
		case (pcSel)
			corePkg::PC_IMM: nextPc = imm;
			corePkg::PC_REG: nextPc = srcData;
			default: nextPc = pc + 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= corePkg::FETCH;
			pc <= '0;
			cyc <= 1'b0;
			we <= 1'b0;
			adr <= '0;
		end else begin
			case (state)
				corePkg::FETCH: begin
					if (!cyc) begin
						cyc <= 1'b1;
						we <= 1'b0;
						adr <= pc;
					end else if (ack) begin
						cyc <= 1'b0;
						state <= corePkg::EXEC;
					end
				end
				corePkg::EXEC: begin
					if (halt) begin
						state <= corePkg::HALTED;
					end else if (memRead || memWrite) begin
						// ST addresses through dst and LD through src
						cyc <= 1'b1;
						we <= memWrite;
						adr <= memWrite ? dstData : srcData;
						state <= corePkg::MEMACC;
					end else begin
						// Next fetch starts straight away
						pc <= nextPc;
						cyc <= 1'b1;
						we <= 1'b0;
						adr <= nextPc;
						state <= corePkg::FETCH;
					end
				end
				corePkg::MEMACC: begin
					if (ack) begin
						cyc <= 1'b0;
						we <= 1'b0;
						pc <= pc + 1'b1;
						state <= corePkg::FETCH;
					end
				end
				default: begin
					cyc <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == corePkg::FETCH) && cyc && ack) begin
			instr <= datIn;
		end
		if ((state == corePkg::EXEC) && memWrite) begin
			datOut <= srcData;
		end
	end

endmodule

`default_nettype wire

// File: test/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic int randomBelow(input int n);
	genState = xorshift(genState);
	return int'(genState % n);
endfunction

task automatic checkValue(input string name, input logic [15:0] got,
	input logic [15:0] expected);
	if (got !== expected) begin
		$display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
		errorCount++;
	end
endtask

function automatic void expectTransfer(input logic [15:0] a, input logic w,
	input logic [15:0] d);
	expAdr.push_back(a);
	expWe.push_back(w);
	expDat.push_back(d);
endfunction

task automatic compareTransfer(input logic [15:0] a, input logic w, input logic [15:0] d);
	if (transferCount >= expAdr.size()) begin
		$display("bus transfer at adr 0x%h goes beyond the %0d expected", a, expAdr.size());
		errorCount++;
	end else begin
		checkValue("adr", a, expAdr[transferCount]);
		checkValue("we", w, expWe[transferCount]);
		if (expWe[transferCount]) begin
			checkValue("datOut", d, expDat[transferCount]);
		end
	end
	transferCount++;
endtask

task automatic buildProgram();
	bit second [ProgWords];
	int jumpSlots [$];
	int pc;
	int pick;
	int target;
	logic [3:0] ra;
	logic [3:0] rb;
	isaPkg::opcodeT op;
	for (int a = 0; a < MemWords; a++) begin
		progImage[a] = (a >= DataBase) ? 16'(randomBelow(65536)) : 16'h0000;
	end
	pc = 0;
	while (pc < ProgWords - 1) begin
		pick = randomBelow(16);
		ra = 4'(randomBelow(16));
		rb = 4'(randomBelow(16));
		if (pick < 7) begin
			op = isaPkg::opcodeT'(4'(1 + randomBelow(6)));
			progImage[pc] = {op, ra, rb, 4'(randomBelow(16))};
		end else if (pick < 9) begin
			progImage[pc] = {isaPkg::LDI, ra, 8'(randomBelow(256))};
		end else if (pick == 9) begin
			progImage[pc] = {isaPkg::MOV, ra, rb, 4'h0};
		end else if (pick < 14 && pc < ProgWords - 2) begin
			// LDI sets the address or jump target for the second word of a pair
			second[pc + 1] = 1'b1;
			if (pick == 13) begin
				jumpSlots.push_back(pc + 1);
				progImage[pc + 1] = {isaPkg::JR, 4'h0, ra, 4'h0};
			end else if (pick == 12) begin
				progImage[pc] = {isaPkg::LDI, ra, 8'(DataBase + randomBelow(128))};
				progImage[pc + 1] = {isaPkg::ST, ra, rb, 4'h0};
			end else begin
				progImage[pc] = {isaPkg::LDI, rb, 8'(DataBase + randomBelow(128))};
				progImage[pc + 1] = {isaPkg::LD, ra, rb, 4'h0};
			end
			pc++;
		end else if (pick >= 14) begin
			pick = randomBelow(3);
			op = (pick == 0) ? isaPkg::JMP : ((pick == 1) ? isaPkg::BZ : isaPkg::BC);
			progImage[pc] = {op, 12'h000};
			jumpSlots.push_back(pc);
		end
		pc++;
	end
	progImage[ProgWords - 1] = {isaPkg::HALT, 12'h000};
	// Targets point forward and skip the second word of a pair
	foreach (jumpSlots[i]) begin
		pc = jumpSlots[i];
		target = pc + 1 + randomBelow(ProgWords - 1 - pc);
		if (second[target]) begin
			target++;
		end
		if (progImage[pc][15:12] == isaPkg::JR) begin
			progImage[pc - 1] = {isaPkg::LDI, progImage[pc][7:4], 8'(target)};
		end else begin
			progImage[pc][7:0] = 8'(target);
		end
	end
endtask

task automatic runModel();
	logic [15:0] image [MemWords];
	logic [15:0] regs [16];
	logic [15:0] pc;
	logic [15:0] instr;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] imm;
	logic [15:0] res;
	logic [3:0] rd;
	logic carry;
	logic c;
	logic z;
	bit done;
	int steps;
	isaPkg::opcodeT op;
	expAdr.delete();
	expWe.delete();
	expDat.delete();
	foreach (progImage[i]) begin
		image[i] = progImage[i];
	end
	foreach (regs[i]) begin
		regs[i] = '0;
	end
	pc = '0;
	c = 1'b0;
	z = 1'b0;
	done = 1'b0;
	steps = 0;
	while (!done && steps < MaxSteps) begin
		expectTransfer(pc, 1'b0, 16'h0000);
		instr = image[pc[7:0]];
		op = isaPkg::opcodeT'(instr[15:12]);
		rd = instr[11:8];
		a = regs[rd];
		b = regs[instr[7:4]];
		imm = {8'h00, instr[7:0]};
		pc = pc + 16'd1;
		case (op)
			isaPkg::ADD: res = a + b;
			isaPkg::SUB: res = a - b;
			isaPkg::AND: res = a & b;
			isaPkg::OR: res = a | b;
			isaPkg::XOR: res = a ^ b;
			isaPkg::SHR: res = a >> 1;
			default: res = '0;
		endcase
		// Carry out, borrow, or the bit shifted out
		case (op)
			isaPkg::ADD: carry = ({1'b0, a} + {1'b0, b}) > 17'h0FFFF;
			isaPkg::SUB: carry = a < b;
			isaPkg::SHR: carry = a[0];
			default: carry = 1'b0;
		endcase
		if (op == isaPkg::ADD || op == isaPkg::SUB || op == isaPkg::AND ||
			op == isaPkg::OR || op == isaPkg::XOR || op == isaPkg::SHR) begin
			regs[rd] = res;
			c = carry;
			z = (res == 16'h0000);
		end
		case (op)
			isaPkg::MOV: regs[rd] = b;
			isaPkg::LDI: regs[rd] = imm;
			isaPkg::LD: begin
				expectTransfer(b, 1'b0, 16'h0000);
				regs[rd] = image[b[7:0]];
			end
			isaPkg::ST: begin
				expectTransfer(a, 1'b1, b);
				image[a[7:0]] = b;
			end
			isaPkg::JMP: pc = imm;
			isaPkg::JR: pc = b;
			isaPkg::BZ: pc = z ? imm : pc;
			isaPkg::BC: pc = c ? imm : pc;
			isaPkg::HALT: done = 1'b1;
			default: begin
			end
		endcase
		steps++;
	end
	if (!done) begin
		$display("model: program did not reach HALT within %0d steps", MaxSteps);
		errorCount++;
	end
endtask

`endif

// File: test/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb;

	localparam int NumPrograms = 6;
	localparam int NumTests = NumPrograms * 2;
	localparam int MemWords = 256;
	localparam int ProgWords = 96;
	localparam int DataBase = 128;
	localparam int MaxSteps = 200;
	localparam int RunCycleLimit = 2000;
	localparam int ClkPeriodNs = 4;
	localparam int WatchdogNs = NumTests * MaxSteps * 12 * ClkPeriodNs;

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [15:0] adr;
	logic [15:0] datOut;
	logic [15:0] datIn;
	logic ack;
	logic halted;

	logic [15:0] mem [MemWords];
	logic [15:0] progImage [MemWords];
	logic [15:0] expAdr [$];
	logic expWe [$];
	logic [15:0] expDat [$];
	logic [31:0] genState;
	logic [31:0] ackState;
	int errorCount;
	int testsOk;
	int transferCount;
	bit slowAck;

	`include "isaModel.svh"

	cpuCore cpuCore_i (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datOut(datOut),
		.datIn(datIn),
		.ack(ack),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriodNs / 2) clk = ~clk;
	end

	// Wishbone slave of 256 words acking after 0 to 3 wait cycles
	initial begin : memorySlave
		logic busy;
		int waitLeft;
		logic [15:0] heldAdr;
		logic heldWe;
		logic [15:0] heldDat;
		ack = 1'b0;
		datIn = '0;
		busy = 1'b0;
		waitLeft = 0;
		forever begin
			@(posedge clk);
			#1;
			if (rst || ack) begin
				ack = 1'b0;
				busy = 1'b0;
			end else if (stb) begin
				if (!busy) begin
					busy = 1'b1;
					heldAdr = adr;
					heldWe = we;
					heldDat = datOut;
					waitLeft = 0;
					if (slowAck) begin
						ackState = xorshift(ackState);
						waitLeft = ackState % 4;
					end
					compareTransfer(heldAdr, heldWe, heldDat);
				end else begin
					checkValue("adr", adr, heldAdr);
					checkValue("we", we, heldWe);
					checkValue("datOut", datOut, heldDat);
				end
				if (waitLeft == 0) begin
					ack = 1'b1;
					if (heldWe) begin
						mem[heldAdr[7:0]] = heldDat;
					end else begin
						datIn = mem[heldAdr[7:0]];
					end
				end else begin
					waitLeft--;
				end
			end
		end
	end

	task automatic runTest(input int testIndex, input int progIndex, input bit slow);
		int errorsBefore;
		int cycles;
		errorsBefore = errorCount;
		slowAck = slow;
		transferCount = 0;
		foreach (progImage[i]) begin
			mem[i] = progImage[i];
		end
		rst = 1'b1;
		repeat (5) begin
			@(posedge clk);
			#1;
			checkValue("cyc", cyc, 1'b0);
			checkValue("stb", stb, 1'b0);
			checkValue("halted", halted, 1'b0);
		end
		rst = 1'b0;
		cycles = 0;
		while (!halted && cycles < RunCycleLimit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!halted) begin
			$display("test %0d: core did not halt within %0d cycles", testIndex, RunCycleLimit);
			errorCount++;
		end
		checkValue("transferCount", transferCount, expAdr.size());
		// Bus must stay quiet once halted
		repeat (20) begin
			@(posedge clk);
			#1;
			if (stb) begin
				$display("test %0d: bus strobe raised after halt", testIndex);
				errorCount++;
			end
		end
		if (errorCount == errorsBefore) begin
			testsOk++;
		end
		$display("test %0d, program %0d, %s ack: %s, %0d transfers", testIndex, progIndex,
			slow ? "random" : "immediate", (errorCount == errorsBefore) ? "ok" : "FAILED",
			transferCount);
	endtask

	initial begin : mainFlow
		rst = 1'b1;
		errorCount = 0;
		testsOk = 0;
		transferCount = 0;
		slowAck = 1'b0;
		genState = 32'd10811;
		ackState = 32'd10811;
		for (int p = 0; p < NumPrograms; p++) begin
			buildProgram();
			runModel();
			runTest(2 * p, p, 1'b0);
			runTest(2 * p + 1, p, 1'b1);
		end
		$display("%0d of %0d tests ok, %0d errors", testsOk, NumTests, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(WatchdogNs);
		$display("watchdog expired after %0d ns, run stopped", WatchdogNs);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+test
src/isaPkg.sv
src/corePkg.sv
src/registerFile.sv
src/alu.sv
src/decoder.sv
src/cpuCore.sv
test/coreTb.sv
